// File: fpu.f
+incdir+verilog
+incdir+sim
verilog/fpu_pkg.sv
verilog/fpu_stage_if.sv
verilog/fpu_operand_decode.sv
verilog/fpu_simple_exec.sv
verilog/fpu.sv
sim/tb_fpu.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the FPU testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --assert --timing -f fpu.f --top-module tb_fpu -o tb_fpu \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_fpu > sim.log 2>&1
cat sim.log
grep -qx "Done: no errors" sim.log \
  && { echo "Simulation passed"; exit 0; } \
  || { echo "Simulation failed"; exit 1; }

// File: sim/fpu_tb_model.svh
`ifndef FPU_TB_MODEL_SVH
`define FPU_TB_MODEL_SVH

// ========================================
// Reference rules for the kept operations
// ========================================
function automatic logic nan_word(input logic [31:0] w);
  return (&w[30:23]) && (|w[22:0]);         // Exponent all ones, mantissa nonzero
endfunction

function automatic logic snan_word(input logic [31:0] w);
  return nan_word(w) && !w[22];             // Quiet bit clear
endfunction

// Unsigned key that rises with the value, -0 just below +0
function automatic logic [31:0] order_key(input logic [31:0] w);
  return w[31] ? ~w : (w | 32'h8000_0000);
endfunction

function automatic logic [9:0] class_onehot(input logic [31:0] w);
  int idx;
  if (snan_word(w))
    idx = 8;
  else if (nan_word(w))
    idx = 9;
  else if (&w[30:23])
    idx = w[31] ? 0 : 7;                    // Infinity
  else if (w[30:0] == 31'd0)
    idx = w[31] ? 3 : 4;                    // Zero
  else if (w[30:23] == 8'd0)
    idx = w[31] ? 2 : 5;                    // Subnormal
  else
    idx = w[31] ? 1 : 6;
  return 10'd1 << idx;
endfunction

function automatic logic op_known(input logic [4:0] op);
  return op inside {FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_MIN, FP_MAX,
                    FP_CMP, FP_CLASS, FP_MV_XW, FP_MV_WX};
endfunction

// Expected fp_result, int_result and flag_nv of one operation
function automatic void predict(input logic [4:0] op, input logic [2:0] f3,
                                input logic [31:0] a, input logic [31:0] b,
                                input logic [31:0] iv, output logic [31:0] fp_exp,
                                output logic [31:0] int_exp, output logic nv_exp);
  logic any_nan;
  logic any_snan;
  logic key_lt;
  logic same;
  logic below;
  any_nan  = nan_word(a) || nan_word(b);
  any_snan = snan_word(a) || snan_word(b);
  key_lt   = order_key(a) < order_key(b);
  same     = !any_nan && ((a[30:0] == 31'd0 && b[30:0] == 31'd0) || a == b); // +0 == -0
  below    = !any_nan && !same && key_lt;
  fp_exp   = '0;
  int_exp  = '0;
  nv_exp   = 1'b0;
  case (op)
    FP_SGNJ:  fp_exp = {b[31], a[30:0]};
    FP_SGNJN: fp_exp = {!b[31], a[30:0]};
    FP_SGNJX: fp_exp = {a[31] ^ b[31], a[30:0]};
    FP_MIN, FP_MAX: begin
      nv_exp = any_snan;
      if (nan_word(a) && nan_word(b))
        fp_exp = `FPU_CANON_NAN;
      else if (nan_word(a))
        fp_exp = b;                         // Single NaN loses
      else if (nan_word(b))
        fp_exp = a;
      else if ((op == FP_MIN) == key_lt)
        fp_exp = a;
      else
        fp_exp = b;
    end
    FP_CMP: begin
      case (f3)
        `FPU_F3_FLT: int_exp[0] = below;
        `FPU_F3_FLE: int_exp[0] = below || same;
        default:     int_exp[0] = same;     // FEQ and unknown codes
      endcase
      nv_exp = (f3 == `FPU_F3_FLT || f3 == `FPU_F3_FLE) ? any_nan : any_snan;
    end
    FP_CLASS: int_exp = {22'd0, class_onehot(a)};
    FP_MV_XW: int_exp = a;
    FP_MV_WX: fp_exp  = iv;
    default: ;
  endcase
endfunction

`endif

// File: sim/tb_fpu.sv
`timescale 1ns/1ps
`include "fpu_defines.svh"

module tb_fpu;
  import fpu_pkg::*;

  `include "fpu_tb_model.svh"

  // ========================================
  // Run length and operand pools
  // ========================================
  localparam int POOL_N   = 12;
  localparam int N_RAND   = 300;
  localparam int N_SPARSE = 20;            // Each start followed by 4 idle cycles
  localparam int STIM_LEN = 3 + 2 + POOL_N + 6 * POOL_N * POOL_N + N_RAND + 5 * N_SPARSE + 8;
  localparam int TIMEOUT_CYCLES = 2 * STIM_LEN + 20;
  localparam logic [31:0] SEED = 32'h28e0_82d0;

  localparam logic [31:0] POOL [POOL_N] = '{
    32'h0000_0000, 32'h8000_0000,          // +0, -0
    32'h7f80_0000, 32'hff80_0000,          // +inf, -inf
    32'h3f80_0000, 32'hbf80_0000,          // +1.0, -1.0
    32'h0000_0001, 32'h807f_ffff,          // Subnormals
    32'h7fc0_0000, 32'hffc0_0001,          // Quiet NaNs
    32'h7f80_0001, 32'hffa0_0000           // Signaling NaNs
  };

  // Kept opcodes followed by three unsupported ones
  localparam logic [4:0] OP_TABLE [12] = '{
    FP_SGNJ, FP_SGNJN, FP_SGNJX, FP_MIN, FP_MAX, FP_CMP, FP_CLASS, FP_MV_XW, FP_MV_WX,
    5'b00000, 5'b01010, 5'b11111
  };
  localparam logic [2:0] CMP_F3 [4] = '{`FPU_F3_FEQ, `FPU_F3_FLT, `FPU_F3_FLE, 3'b111};

  typedef struct packed {
    logic [31:0] fp;
    logic [31:0] iv;
    logic        nv;
    logic        is_class;               // Needs the one-hot check
  } expect_t;

  logic        clk;
  logic        rst;
  logic        start;
  logic [4:0]  fp_alu_op;
  logic [2:0]  funct3;
  logic [31:0] operand_a;
  logic [31:0] operand_b;
  logic [31:0] int_operand;
  logic        done;
  logic [31:0] fp_result;
  logic [31:0] int_result;
  logic        flag_nv;

  expect_t     exp_q[$];                  // Predicted results in start order
  logic [1:0]  done_pipe = '0;            // Expected done two cycles behind start
  logic        checking  = 1'b0;
  logic [31:0] hold_fp   = '0;            // Last completed operation
  logic [31:0] hold_int  = '0;
  logic        hold_nv   = 1'b0;
  int          cycle_count = 0;

  fpu fpu_i (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .fp_alu_op   (fp_alu_op),
    .funct3      (funct3),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .int_operand (int_operand),
    .done        (done),
    .fp_result   (fp_result),
    .int_result  (int_result),
    .flag_nv     (flag_nv)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expv,
                                 input logic [31:0] actv);
    stop_run($sformatf("FAILED at %0t ns: %s expected %h got %h", $time, name, expv, actv));
  endtask

  function automatic logic [31:0] pick_operand();
    if ($urandom_range(0, 1) == 0)
      return POOL[$urandom_range(0, POOL_N - 1)];
    else
      return $urandom();
  endfunction

  // Drive one start cycle and queue the prediction of a supported opcode
  task automatic issue(input logic [4:0] op, input logic [2:0] f3, input logic [31:0] a,
                       input logic [31:0] b, input logic [31:0] iv);
    logic [31:0] fp_e;
    logic [31:0] int_e;
    logic        nv_e;
    expect_t     e;
    @(posedge clk);
    start       <= 1'b1;
    fp_alu_op   <= op;
    funct3      <= f3;
    operand_a   <= a;
    operand_b   <= b;
    int_operand <= iv;
    if (op_known(op)) begin
      predict(op, f3, a, b, iv, fp_e, int_e, nv_e);
      e = '{fp: fp_e, iv: int_e, nv: nv_e, is_class: (op == FP_CLASS)};
      exp_q.push_back(e);
    end
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      start     <= 1'b0;
      operand_a <= $urandom();            // Noise that must not leak through
      operand_b <= $urandom();
    end
  endtask

  // ========================================
  // Output checks on values from before the edge
  // ========================================
  always @(posedge clk) begin : check_outputs
    expect_t head;
    if (checking) begin
      assert (done == done_pipe[1])
        else report_mismatch("done", {31'd0, done_pipe[1]}, {31'd0, done});
      if (done && exp_q.size() == 0) begin
        stop_run("done pulse arrived with no operation pending");
      end else if (done) begin
        head     = exp_q.pop_front();
        hold_fp  = head.fp;
        hold_int = head.iv;
        hold_nv  = head.nv;
        assert (!head.is_class || $onehot(int_result[`FPU_CLASS_W-1:0]))
          else stop_run("FCLASS result does not have exactly one bit set");
      end
      assert (fp_result == hold_fp) else report_mismatch("fp_result", hold_fp, fp_result);
      assert (int_result == hold_int) else report_mismatch("int_result", hold_int, int_result);
      assert (flag_nv == hold_nv)
        else report_mismatch("flag_nv", {31'd0, hold_nv}, {31'd0, flag_nv});
    end
    done_pipe <= {done_pipe[0], start && op_known(fp_alu_op)};
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_run($sformatf("Timeout after %0d cycles, run did not finish", cycle_count));
  end

  // ========================================
  // Stimulus
  // ========================================
  initial begin
    rst         = 1'b1;
    start       = 1'b0;
    fp_alu_op   = '0;
    funct3      = '0;
    operand_a   = '0;
    operand_b   = '0;
    int_operand = '0;
    void'($urandom(SEED));
    repeat (3) @(posedge clk);
    rst      <= 1'b0;
    checking <= 1'b1;                     // Reset values checked from here
    idle(2);
    for (int i = 0; i < POOL_N; i++)      // Every class value
      issue(FP_CLASS, 3'd0, POOL[i], $urandom(), $urandom());
    for (int i = 0; i < POOL_N; i++) begin
      for (int j = 0; j < POOL_N; j++) begin
        issue(FP_MIN, 3'd0, POOL[i], POOL[j], $urandom());
        issue(FP_MAX, 3'd0, POOL[i], POOL[j], $urandom());
      end
    end
    for (int i = 0; i < POOL_N; i++) begin
      for (int j = 0; j < POOL_N; j++) begin
        for (int f = 0; f < 4; f++)
          issue(FP_CMP, CMP_F3[f], POOL[i], POOL[j], $urandom());
      end
    end
    // Mostly back-to-back with unsupported opcodes mixed in
    for (int k = 0; k < N_RAND; k++) begin
      if ($urandom_range(0, 4) == 0)
        idle(1);
      else
        issue(OP_TABLE[$urandom_range(0, 11)], 3'($urandom_range(0, 7)),
              pick_operand(), pick_operand(), $urandom());
    end
    for (int k = 0; k < N_SPARSE; k++) begin  // Hold between sparse starts
      issue(OP_TABLE[$urandom_range(0, 8)], 3'($urandom_range(0, 7)),
            pick_operand(), pick_operand(), $urandom());
      idle(4);
    end
    idle(8);
    if (exp_q.size() != 0) begin
      stop_run($sformatf("%0d operations never gave a done pulse", exp_q.size()));
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

// File: verilog/fpu.sv
`timescale 1ns/1ps
`include "fpu_defines.svh"

// Two-stage single-cycle FP ops, decode then execute
module fpu (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,        // Launch one operation
  input  logic [`FPU_OP_W-1:0]  fp_alu_op,
  input  logic [2:0]            funct3,
  input  fpu_pkg::fp_word_t     operand_a,
  input  fpu_pkg::fp_word_t     operand_b,
  input  fpu_pkg::fp_word_t     int_operand,
  output logic                  done,         // Two cycles after start
  output fpu_pkg::fp_word_t     fp_result,
  output fpu_pkg::fp_word_t     int_result,
  output logic                  flag_nv
);

  fpu_stage_if stage_if ();  // Stage 1 to stage 2

  // Stage 1, opcode map and operand classes
  fpu_operand_decode decode_i (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .fp_alu_op   (fpu_pkg::fp_alu_op_e'(fp_alu_op)),
    .funct3      (funct3),
    .operand_a   (operand_a),
    .operand_b   (operand_b),
    .int_operand (int_operand),
    .stage       (stage_if)
  );

  // Stage 2, result compute and output registers
  fpu_simple_exec exec_i (
    .clk        (clk),
    .rst        (rst),
    .stage      (stage_if),
    .done       (done),
    .fp_result  (fp_result),
    .int_result (int_result),
    .flag_nv    (flag_nv)
  );

endmodule

// File: verilog/fpu_simple_exec.sv
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_simple_exec (
  input  logic              clk,
  input  logic              rst,
  fpu_stage_if.consumer     stage,
  output logic              done,       // One-cycle completion pulse
  output fpu_pkg::fp_word_t fp_result,
  output fpu_pkg::fp_word_t int_result,
  output logic              flag_nv     // Invalid operation
);
  import fpu_pkg::*;

  // Shared ordering terms
  logic mag_lt;      // |a| < |b|
  logic mag_eq;      // |a| == |b|
  logic a_lt_b;      // Total order, -0 below +0, NaN excluded by callers
  logic both_zero;
  logic any_nan;
  logic any_snan;

  logic [`FPU_CLASS_W-1:0] class_mask;
  logic                    a_normal;

  fp_word_t fp_next;
  fp_word_t int_next;
  logic     nv_next;

  // ========================================
  // Magnitude compare
  // ========================================
  assign mag_lt    = stage.a[`FPU_FLEN-2:0] < stage.b[`FPU_FLEN-2:0];
  assign mag_eq    = stage.a[`FPU_FLEN-2:0] == stage.b[`FPU_FLEN-2:0];
  assign both_zero = stage.a_cls.is_zero && stage.b_cls.is_zero;
  assign any_nan   = stage.a_cls.is_nan || stage.b_cls.is_nan;
  assign any_snan  = stage.a_cls.is_snan || stage.b_cls.is_snan;

  always_comb begin
    if (stage.a_cls.sign != stage.b_cls.sign)
      a_lt_b = stage.a_cls.sign;           // Negative side is smaller
    else if (stage.a_cls.sign)
      a_lt_b = !mag_lt && !mag_eq;         // Both negative, larger magnitude wins
    else
      a_lt_b = mag_lt;                     // Both positive
  end

  // ========================================
  // Classify mask of operand a
  // ========================================
  assign a_normal = !stage.a_cls.is_zero && !stage.a_cls.is_subnormal &&
                    !stage.a_cls.is_inf && !stage.a_cls.is_nan;

  always_comb begin
    class_mask    = '0;
    class_mask[0] = stage.a_cls.sign && stage.a_cls.is_inf;        // -inf
    class_mask[1] = stage.a_cls.sign && a_normal;
    class_mask[2] = stage.a_cls.sign && stage.a_cls.is_subnormal;
    class_mask[3] = stage.a_cls.sign && stage.a_cls.is_zero;       // -0
    class_mask[4] = !stage.a_cls.sign && stage.a_cls.is_zero;      // +0
    class_mask[5] = !stage.a_cls.sign && stage.a_cls.is_subnormal;
    class_mask[6] = !stage.a_cls.sign && a_normal;
    class_mask[7] = !stage.a_cls.sign && stage.a_cls.is_inf;       // +inf
    class_mask[8] = stage.a_cls.is_snan;                           // NaN sign ignored
    class_mask[9] = stage.a_cls.is_nan && !stage.a_cls.is_snan;
  end

  // ========================================
  // Result select
  // ========================================
  always_comb begin
    fp_next  = '0;
    int_next = '0;
    nv_next  = 1'b0;
    case (stage.op)
      OP_SGNJ:  fp_next = {stage.b[`FPU_FLEN-1], stage.a[`FPU_FLEN-2:0]};
      OP_SGNJN: fp_next = {~stage.b[`FPU_FLEN-1], stage.a[`FPU_FLEN-2:0]};
      OP_SGNJX: fp_next = {stage.a[`FPU_FLEN-1] ^ stage.b[`FPU_FLEN-1],
                           stage.a[`FPU_FLEN-2:0]};
      OP_MIN, OP_MAX: begin
        nv_next = any_snan;
        if (stage.a_cls.is_nan && stage.b_cls.is_nan)
          fp_next = `FPU_CANON_NAN;
        else if (stage.a_cls.is_nan)
          fp_next = stage.b;                 // Other operand survives
        else if (stage.b_cls.is_nan)
          fp_next = stage.a;
        else if (stage.op == OP_MIN)
          fp_next = a_lt_b ? stage.a : stage.b;
        else
          fp_next = a_lt_b ? stage.b : stage.a;
      end
      OP_FEQ: begin
        nv_next     = any_snan;              // Quiet compare
        int_next[0] = !any_nan && (both_zero || (stage.a == stage.b));
      end
      OP_FLT: begin
        nv_next     = any_nan;               // Signaling compare
        int_next[0] = !any_nan && !both_zero && a_lt_b;
      end
      OP_FLE: begin
        nv_next     = any_nan;
        int_next[0] = !any_nan && (both_zero || a_lt_b || (stage.a == stage.b));
      end
      OP_CLASS: int_next[`FPU_CLASS_W-1:0] = class_mask;
      OP_MV_XW: int_next = stage.a;          // Raw bit move
      OP_MV_WX: fp_next  = stage.int_val;
      default: begin
        fp_next  = '0;
        int_next = '0;
      end
    endcase
  end

  // ========================================
  // Stage 2 register
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      done       <= 1'b0;
      fp_result  <= '0;
      int_result <= '0;
      flag_nv    <= 1'b0;
    end else begin
      done <= stage.valid;
      if (stage.valid) begin                 // Hold last result otherwise
        fp_result  <= fp_next;
        int_result <= int_next;
        flag_nv    <= nv_next;
      end
    end
  end

endmodule

// File: verilog/fpu_operand_decode.sv
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fpu_operand_decode (
  input  logic                clk,
  input  logic                rst,
  input  logic                start,        // Operation strobe
  input  fpu_pkg::fp_alu_op_e fp_alu_op,
  input  logic [2:0]          funct3,       // Compare kind for CMP
  input  fpu_pkg::fp_word_t   operand_a,
  input  fpu_pkg::fp_word_t   operand_b,
  input  fpu_pkg::fp_word_t   int_operand,
  fpu_stage_if.producer       stage
);
  import fpu_pkg::*;

  fpu_op_e op_next;    // Mapped internal operation
  logic    supported;  // Opcode handled by this unit

  // Split a word into its fields and flag its class
  function automatic fp_class_t classify(input fp_word_t w);
    logic [`FPU_EXP_W-1:0] exp_f;
    logic [`FPU_MAN_W-1:0] man_f;
    fp_class_t             c;
    exp_f          = w[`FPU_FLEN-2 -: `FPU_EXP_W];
    man_f          = w[`FPU_MAN_W-1:0];
    c.sign         = w[`FPU_FLEN-1];
    c.is_zero      = (exp_f == '0) && (man_f == '0);
    c.is_subnormal = (exp_f == '0) && (man_f != '0);
    c.is_inf       = (&exp_f) && (man_f == '0);
    c.is_nan       = (&exp_f) && (man_f != '0);
    c.is_snan      = c.is_nan && !man_f[`FPU_MAN_W-1]; // Quiet bit clear
    return c;
  endfunction

  // ========================================
  // Opcode map
  // ========================================
  always_comb begin
    op_next   = OP_SGNJ;
    supported = 1'b1;
    case (fp_alu_op)
      FP_SGNJ:  op_next = OP_SGNJ;
      FP_SGNJN: op_next = OP_SGNJN;
      FP_SGNJX: op_next = OP_SGNJX;
      FP_MIN:   op_next = OP_MIN;
      FP_MAX:   op_next = OP_MAX;
      FP_CMP: begin
        case (funct3)
          `FPU_F3_FEQ: op_next = OP_FEQ;
          `FPU_F3_FLT: op_next = OP_FLT;
          `FPU_F3_FLE: op_next = OP_FLE;
          default:     op_next = OP_FEQ; // Unknown funct3 acts as FEQ
        endcase
      end
      FP_CLASS: op_next = OP_CLASS;
      FP_MV_XW: op_next = OP_MV_XW;
      FP_MV_WX: op_next = OP_MV_WX;
      default:  supported = 1'b0;      // Dropped here, never reaches done
    endcase
  end

  // ========================================
  // Stage 1 register
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      stage.valid   <= 1'b0;
      stage.op      <= OP_SGNJ;
      stage.a       <= '0;
      stage.b       <= '0;
      stage.int_val <= '0;
      stage.a_cls   <= '0;
      stage.b_cls   <= '0;
    end else begin
      stage.valid <= start && supported;
      // Payload only moves for a real operation
      if (start && supported) begin
        stage.op      <= op_next;
        stage.a       <= operand_a;
        stage.b       <= operand_b;
        stage.int_val <= int_operand;
        stage.a_cls   <= classify(operand_a);
        stage.b_cls   <= classify(operand_b);
      end
    end
  end

endmodule

// File: verilog/fpu_stage_if.sv
`timescale 1ns/1ps

// One decoded operation between decode and execute stages
interface fpu_stage_if;
  import fpu_pkg::*;

  logic      valid;    // One-cycle strobe per operation
  fpu_op_e   op;       // Internal operation
  fp_word_t  a;        // FP operand a
  fp_word_t  b;        // FP operand b
  fp_word_t  int_val;  // Integer operand for FMV.W.X
  fp_class_t a_cls;    // Class of a
  fp_class_t b_cls;    // Class of b

  // Decode side drives everything
  modport producer (
    output valid, op, a, b, int_val, a_cls, b_cls
  );

  // Execute side only reads
  modport consumer (
    input valid, op, a, b, int_val, a_cls, b_cls
  );

endinterface

// File: verilog/fpu_pkg.sv
`include "fpu_defines.svh"

package fpu_pkg;

  // One single-precision word
  typedef logic [`FPU_FLEN-1:0] fp_word_t;

  // External opcode, encodings shared with the control unit
  typedef enum logic [`FPU_OP_W-1:0] {
    FP_SGNJ  = 5'b00101,
    FP_SGNJN = 5'b00110,
    FP_SGNJX = 5'b00111,
    FP_MIN   = 5'b01000,
    FP_MAX   = 5'b01001,
    FP_CMP   = 5'b01011, // Compare kind comes from funct3
    FP_CLASS = 5'b01100,
    FP_MV_XW = 5'b10001, // FP bits to integer side
    FP_MV_WX = 5'b10010  // Integer bits to FP side
  } fp_alu_op_e;

  // Internal operation, compare already split by funct3
  typedef enum logic [3:0] {
    OP_SGNJ, OP_SGNJN, OP_SGNJX,
    OP_MIN, OP_MAX,
    OP_FEQ, OP_FLT, OP_FLE,
    OP_CLASS,
    OP_MV_XW, OP_MV_WX
  } fpu_op_e;

  // Operand class bits, found once in stage 1
  typedef struct packed {
    logic sign;
    logic is_zero;
    logic is_subnormal;
    logic is_inf;
    logic is_nan;
    logic is_snan;       // Top mantissa bit clear, mantissa nonzero
  } fp_class_t;

endpackage

// File: verilog/fpu_defines.svh
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// ========================================
// Word format, IEEE 754 single precision
// ========================================
`define FPU_FLEN      32            // Floating-point word width
`define FPU_EXP_W     8             // Exponent field width
`define FPU_MAN_W     23            // Mantissa field width
`define FPU_CANON_NAN 32'h7fc0_0000 // Canonical quiet NaN

// ========================================
// Control fields
// ========================================
`define FPU_OP_W      5             // External opcode width
`define FPU_F3_FEQ    3'b010        // funct3 compare codes
`define FPU_F3_FLT    3'b001
`define FPU_F3_FLE    3'b000

`define FPU_CLASS_W   10            // FCLASS one-hot mask width

`endif
